// ==== project.f ====
logic/dlx_pkg.sv
logic/reg_file.sv
logic/inst_fetch.sv
logic/decode_ctrl.sv
logic/hazard_forward.sv
logic/alu_execute.sv
logic/pipeline.sv
dv/pipeline_assertions.sv
dv/pipeline_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module pipeline_tb \
  -f project.f -o sim_pipeline

status=0
./obj_dir/sim_pipeline > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation failed"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without passing"
  exit 1
fi
echo "simulation passed"

// ==== dv/pipeline_tb.sv ====
`timescale 1ns/1ps

module pipeline_tb;
  import dlx_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int SEED         = 23817;
  // cycles allowed for one program to produce its stores
  localparam int RUN_LIMIT    = 120;
  // extra cycles after the last store, catches stray stores
  localparam int DRAIN_CYCLES = 10;
  // six tests, the reset test starts its program twice
  localparam int NUM_RUNS     = 7;
  localparam int RUN_CYCLES   = RESET_CYCLES + RUN_LIMIT + DRAIN_CYCLES + 8;
  localparam int WATCHDOG_CYC = NUM_RUNS * RUN_CYCLES + 100;
  localparam int MEM_WORDS    = 64;

  localparam word_t    NOP = '0;
  localparam reg_idx_t R0  = 5'd0;
  localparam reg_idx_t R1  = 5'd1;
  localparam reg_idx_t R2  = 5'd2;
  localparam reg_idx_t R3  = 5'd3;
  localparam reg_idx_t R4  = 5'd4;

  logic  clk;
  logic  rst_n;
  word_t instruction;
  word_t mem_read_data;
  word_t pc;
  word_t mem_addr;
  word_t mem_write_data;
  logic  mem_wr;

  word_t imem [MEM_WORDS];
  word_t dmem [MEM_WORDS];

  // program under construction, expected and seen stores
  word_t prog [$];
  word_t want_addr [$];
  word_t want_data [$];
  word_t seen_addr [$];
  word_t seen_data [$];

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  pipeline u_pipeline (
    .clk            (clk),
    .rst_n          (rst_n),
    .instruction    (instruction),
    .mem_read_data  (mem_read_data),
    .pc             (pc),
    .mem_addr       (mem_addr),
    .mem_write_data (mem_write_data),
    .mem_wr         (mem_wr)
  );

  ////////////////////////////////////////////////////////////
  // memory models
  ////////////////////////////////////////////////////////////

  // word addressed, combinational reads
  assign instruction   = imem[pc[7:2]];
  assign mem_read_data = dmem[mem_addr[7:2]];

  // store lands on the rising edge
  always @(posedge clk) begin
    if (mem_wr) begin
      dmem[mem_addr[7:2]] = mem_write_data;
    end
  end

  // log each store mid cycle
  always @(negedge clk) begin
    if (rst_n && mem_wr) begin
      seen_addr.push_back(mem_addr);
      seen_data.push_back(mem_write_data);
    end
  end

  ////////////////////////////////////////////////////////////
  // encoders and helpers
  ////////////////////////////////////////////////////////////

  function automatic word_t enc_r(func_e f, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
    return {RTYPE, rs1, rs2, rd, 5'd0, f};
  endfunction

  // rt is the destination, or the store source
  function automatic word_t enc_i(opcode_e op, reg_idx_t rt, reg_idx_t rs1,
                                  logic [15:0] imm);
    return {op, rs1, rt, imm};
  endfunction

  function automatic word_t enc_j(logic [25:0] target);
    return {J, target};
  endfunction

  // word offset counted from the delay slot
  function automatic logic [15:0] br_off(int at, int target);
    return 16'(target - at - 1);
  endfunction

  function automatic word_t sext16(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic word_t signed_less(word_t x, word_t y);
    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
  endfunction

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t got, word_t expected);
    if (got !== expected) begin
      abort_run($sformatf("error at %0t ns: %s is %h, expected %h",
                          $time, name, got, expected));
    end
  endtask

  task automatic check_store(word_t got_addr, word_t got_data,
                             word_t exp_addr, word_t exp_data);
    check_word("mem_addr", got_addr, exp_addr);
    check_word("mem_write_data", got_data, exp_data);
  endtask

  task automatic new_program();
    prog.delete();
    want_addr.delete();
    want_data.delete();
  endtask

  task automatic emit(word_t instr);
    prog.push_back(instr);
  endtask

  task automatic expect_store(word_t addr, word_t data);
    want_addr.push_back(addr);
    want_data.push_back(data);
  endtask

  // reset, load code with a jump-to-self halt, clear data
  task automatic start_program();
    int halt_idx;
    halt_idx = prog.size();
    @(negedge clk);
    rst_n = 1'b0;
    foreach (imem[i]) begin
      if (i < halt_idx) begin
        imem[i] = prog[i];
      end else if (i == halt_idx) begin
        imem[i] = enc_j(26'(halt_idx));
      end else begin
        imem[i] = NOP;
      end
    end
    foreach (dmem[i]) begin
      dmem[i] = '0;
    end
    seen_addr.delete();
    seen_data.delete();
    repeat (RESET_CYCLES) @(negedge clk);
    check_word("pc", pc, RESET_PC);
    rst_n = 1'b1;
  endtask

  task automatic run_and_compare(string name);
    int cycles;
    cycles = 0;
    while ((seen_addr.size() < want_addr.size()) && (cycles < RUN_LIMIT)) begin
      @(posedge clk);
      cycles++;
    end
    if (seen_addr.size() < want_addr.size()) begin
      abort_run($sformatf("%s: timed out, %0d of %0d stores seen after %0d cycles",
                          name, seen_addr.size(), want_addr.size(), cycles));
    end
    repeat (DRAIN_CYCLES) @(posedge clk);
    if (seen_addr.size() != want_addr.size()) begin
      abort_run($sformatf("%s: %0d stores seen, only %0d expected",
                          name, seen_addr.size(), want_addr.size()));
    end
    foreach (want_addr[i]) begin
      check_store(seen_addr[i], seen_data[i], want_addr[i], want_data[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  // one op into r3, stored right behind it
  task automatic alu_case(word_t instr, word_t expected, logic [15:0] addr);
    emit(instr);
    emit(enc_i(SW, R3, R0, addr));
    expect_store({16'h0000, addr}, expected);
  endtask

  task automatic test_alu_ops();
    logic [15:0] ia;
    logic [15:0] ib;
    logic [15:0] ic;
    word_t       a;
    word_t       b;
    word_t       c_s;
    word_t       c_z;
    ia  = 16'($urandom());
    ib  = 16'($urandom());
    ic  = 16'($urandom());
    a   = sext16(ia);
    b   = sext16(ib);
    c_s = sext16(ic);
    // logic immediates are zero extended
    c_z = {16'h0000, ic};
    new_program();
    emit(enc_i(ADDI, R1, R0, ia));
    emit(enc_i(ADDI, R2, R0, ib));
    alu_case(enc_r(FUNC_ADD, R3, R1, R2), a + b, 16'd0);
    alu_case(enc_r(FUNC_SUB, R3, R1, R2), a - b, 16'd4);
    alu_case(enc_r(FUNC_AND, R3, R1, R2), a & b, 16'd8);
    alu_case(enc_r(FUNC_OR,  R3, R1, R2), a | b, 16'd12);
    alu_case(enc_r(FUNC_XOR, R3, R1, R2), a ^ b, 16'd16);
    alu_case(enc_r(FUNC_SLT, R3, R1, R2), signed_less(a, b), 16'd20);
    alu_case(enc_i(ADDI, R3, R1, ic), a + c_s, 16'd24);
    alu_case(enc_i(SUBI, R3, R1, ic), a - c_s, 16'd28);
    alu_case(enc_i(ANDI, R3, R1, ic), a & c_z, 16'd32);
    alu_case(enc_i(ORI,  R3, R1, ic), a | c_z, 16'd36);
    alu_case(enc_i(XORI, R3, R1, ic), a ^ c_z, 16'd40);
    alu_case(enc_i(SLTI, R3, R1, ic), signed_less(a, c_s), 16'd44);
    start_program();
    run_and_compare("alu ops");
  endtask

  task automatic test_load_use();
    logic [15:0] iv;
    word_t       v;
    iv = 16'($urandom());
    v  = sext16(iv);
    new_program();
    emit(enc_i(ADDI, R1, R0, iv));
    emit(enc_i(SW, R1, R0, 16'd64));
    emit(enc_i(LW, R2, R0, 16'd64));
    // consumer right behind the load
    emit(enc_r(FUNC_ADD, R3, R2, R1));
    emit(enc_i(SW, R3, R0, 16'd68));
    expect_store(32'd64, v);
    expect_store(32'd68, v + v);
    start_program();
    run_and_compare("load use");
  endtask

  task automatic test_branches();
    new_program();
    emit(enc_i(ADDI, R1, R0, 16'd1));
    emit(enc_i(ADDI, R2, R0, 16'h0011));
    emit(enc_i(ADDI, R3, R0, 16'h0022));
    // r1 becomes zero one slot before the branch
    emit(enc_i(SUBI, R1, R1, 16'd1));
    emit(enc_i(BEQZ, R0, R1, br_off(4, 7)));
    emit(enc_i(SW, R2, R0, 16'd0));
    emit(enc_i(SW, R3, R0, 16'd4));
    emit(enc_i(SW, R3, R0, 16'd8));
    emit(enc_i(ADDI, R4, R0, 16'd5));
    // not taken, r4 is fresh
    emit(enc_i(BEQZ, R0, R4, br_off(9, 12)));
    emit(enc_i(SW, R2, R0, 16'd12));
    emit(enc_i(SW, R3, R0, 16'd16));
    emit(enc_i(BNEZ, R0, R4, br_off(12, 15)));
    emit(enc_i(SW, R4, R0, 16'd20));
    emit(enc_i(SW, R2, R0, 16'd24));
    // r0 never branches on bnez
    emit(enc_i(BNEZ, R0, R0, br_off(15, 18)));
    emit(enc_i(SW, R3, R0, 16'd28));
    emit(enc_i(SW, R4, R0, 16'd32));
    expect_store(32'd0, 32'h11);
    expect_store(32'd8, 32'h22);
    expect_store(32'd12, 32'h11);
    expect_store(32'd16, 32'h22);
    expect_store(32'd20, 32'd5);
    expect_store(32'd28, 32'h22);
    expect_store(32'd32, 32'd5);
    start_program();
    run_and_compare("branches");
  endtask

  task automatic test_jump();
    new_program();
    emit(enc_i(ADDI, R1, R0, 16'h0033));
    emit(enc_j(26'd5));
    emit(enc_i(SW, R1, R0, 16'd0));
    emit(enc_i(SW, R1, R0, 16'd4));
    emit(enc_i(SW, R1, R0, 16'd8));
    emit(enc_i(SW, R1, R0, 16'd12));
    expect_store(32'd0, 32'h33);
    expect_store(32'd12, 32'h33);
    start_program();
    run_and_compare("jump");
  endtask

  task automatic test_reg_zero();
    new_program();
    emit(enc_i(ADDI, R0, R0, 16'h0055));
    // must not pick up the r0 write by forwarding
    emit(enc_i(ADDI, R1, R0, 16'd7));
    emit(enc_i(SW, R0, R0, 16'd0));
    emit(enc_i(SW, R1, R0, 16'd4));
    emit(enc_r(FUNC_OR, R0, R1, R1));
    emit(enc_i(SW, R0, R0, 16'd8));
    expect_store(32'd0, 32'd0);
    expect_store(32'd4, 32'd7);
    expect_store(32'd8, 32'd0);
    start_program();
    run_and_compare("register zero");
  endtask

  task automatic test_reset();
    new_program();
    emit(enc_i(ADDI, R1, R0, 16'd9));
    emit(enc_i(ADDI, R2, R1, 16'd1));
    emit(enc_i(SW, R2, R0, 16'd16));
    emit(enc_i(SW, R1, R0, 16'd20));
    expect_store(32'd16, 32'd10);
    expect_store(32'd20, 32'd9);
    start_program();
    // restart with work in flight
    repeat (4) @(posedge clk);
    start_program();
    run_and_compare("reset");
  endtask

  ////////////////////////////////////////////////////////////
  // sequence and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    rst_n = 1'b0;
    void'($urandom(SEED));
    foreach (imem[i]) begin
      imem[i] = NOP;
      dmem[i] = '0;
    end
    test_reset();
    test_alu_ops();
    test_load_use();
    test_branches();
    test_jump();
    test_reg_zero();
    if ((u_pipeline.u_pipeline_assertions.reset_fails +
         u_pipeline.u_pipeline_assertions.stall_fails +
         u_pipeline.u_pipeline_assertions.addr_fails) == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run("concurrent assertion failures were reported");
    end
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    abort_run("watchdog expired, the tests did not finish in time");
  end

endmodule

// ==== dv/pipeline_assertions.sv ====
`timescale 1ns/1ps

module pipeline_assertions (
  input logic           clk,
  input logic           rst_n,
  input logic           stall,
  input dlx_pkg::word_t pc,
  input dlx_pkg::word_t mem_addr,
  input logic           mem_wr
);

  // failure counts, read back by the testbench at the end
  int reset_fails = 0;
  int stall_fails = 0;
  int addr_fails  = 0;

  ////////////////////////////////////////////////////////////
  // properties
  ////////////////////////////////////////////////////////////

  // no store strobe while held in reset
  property p_no_store_in_reset;
    @(posedge clk) !rst_n |-> !mem_wr;
  endproperty

  // stalled fetch keeps the same pc
  property p_pc_held_on_stall;
    @(posedge clk) disable iff (!rst_n) stall |=> $stable(pc);
  endproperty

  // store address fully driven
  property p_store_addr_known;
    @(posedge clk) disable iff (!rst_n) mem_wr |-> !$isunknown(mem_addr);
  endproperty

  a_no_store_in_reset: assert property (p_no_store_in_reset) else begin
    $error("mem_wr high while rst_n is low");
    reset_fails++;
  end

  a_pc_held_on_stall: assert property (p_pc_held_on_stall) else begin
    $error("pc moved during a stall cycle");
    stall_fails++;
  end

  a_store_addr_known: assert property (p_store_addr_known) else begin
    $error("mem_addr has unknown bits during a store");
    addr_fails++;
  end

endmodule

bind pipeline pipeline_assertions u_pipeline_assertions (
  .clk      (clk),
  .rst_n    (rst_n),
  .stall    (stall),
  .pc       (pc),
  .mem_addr (mem_addr),
  .mem_wr   (mem_wr)
);

// ==== logic/pipeline.sv ====
`timescale 1ns/1ps

module pipeline (
  input  logic           clk,
  input  logic           rst_n,
  input  dlx_pkg::word_t instruction,
  input  dlx_pkg::word_t mem_read_data,
  output dlx_pkg::word_t pc,
  output dlx_pkg::word_t mem_addr,
  output dlx_pkg::word_t mem_write_data,
  output logic           mem_wr
);
  import dlx_pkg::*;

  // stage registers
  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;

  // decode outputs
  word_t    rd_a;
  word_t    rd_b;
  ctrl_t    dec_ctrl;
  word_t    imm_ext;
  logic     branch_taken;
  logic     jump;

  // hazard unit outputs
  logic     stall;
  fwd_sel_e fwd_a;
  fwd_sel_e fwd_b;

  // execute and writeback
  word_t    ex_result;
  word_t    ex_store_data;
  word_t    wb_data;
  logic     wb_en;

  ////////////////////////////////////////////////////////////
  // fetch and decode
  ////////////////////////////////////////////////////////////

  inst_fetch u_inst_fetch (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall        (stall),
    .branch_taken (branch_taken),
    .jump         (jump),
    .if_pc        (if_id.pc),
    .imm16        (if_id.instr[15:0]),
    .imm26        (if_id.instr[25:0]),
    .pc           (pc)
  );

  // if_id held while stalled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id <= '0;
    end else if (!stall) begin
      if_id <= '{valid: 1'b1, instr: instruction, pc: pc};
    end
  end

  reg_file u_reg_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_a_idx (if_id.instr[RS1_LSB +: 5]),
    .rd_b_idx (if_id.instr[RS2_LSB +: 5]),
    .rd_a     (rd_a),
    .rd_b     (rd_b),
    .wr_en    (wb_en),
    .wr_idx   (mem_wb.ctrl.dest),
    .wr_data  (wb_data)
  );

  decode_ctrl u_decode_ctrl (
    .if_id        (if_id),
    .rs_val       (rd_a),
    .ctrl         (dec_ctrl),
    .imm_ext      (imm_ext),
    .branch_taken (branch_taken),
    .jump         (jump)
  );

  hazard_forward u_hazard_forward (
    .if_id  (if_id),
    .id_ex  (id_ex),
    .ex_mem (ex_mem),
    .mem_wb (mem_wb),
    .stall  (stall),
    .fwd_a  (fwd_a),
    .fwd_b  (fwd_b)
  );

  // bubble into execute on stall
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex <= '0;
    end else if (stall) begin
      id_ex <= '0;
    end else begin
      id_ex <= '{valid: if_id.valid, ctrl: dec_ctrl, op_a: rd_a, op_b: rd_b,
                 imm: imm_ext, rs1: if_id.instr[RS1_LSB +: 5],
                 rs2: if_id.instr[RS2_LSB +: 5]};
    end
  end

  ////////////////////////////////////////////////////////////
  // execute, memory, writeback
  ////////////////////////////////////////////////////////////

  alu_execute u_alu_execute (
    .id_ex      (id_ex),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .mem_fwd    (ex_mem.alu_result),
    .wb_fwd     (wb_data),
    .result     (ex_result),
    .store_data (ex_store_data)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem <= '0;
      mem_wb <= '0;
    end else begin
      ex_mem <= '{valid: id_ex.valid, ctrl: id_ex.ctrl,
                  alu_result: ex_result, store_data: ex_store_data};
      mem_wb <= '{valid: ex_mem.valid, ctrl: ex_mem.ctrl,
                  alu_result: ex_mem.alu_result, load_data: mem_read_data};
    end
  end

  // data memory port straight from ex_mem
  assign mem_addr       = ex_mem.alu_result;
  assign mem_write_data = ex_mem.store_data;
  assign mem_wr         = ex_mem.valid && ex_mem.ctrl.mem_wr;

  // load data or alu result back to the register file
  assign wb_data = mem_wb.ctrl.mem_to_reg ? mem_wb.load_data : mem_wb.alu_result;
  assign wb_en   = mem_wb.valid && mem_wb.ctrl.reg_wr;

endmodule

// ==== logic/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
  input  dlx_pkg::id_ex_t   id_ex,
  input  dlx_pkg::fwd_sel_e fwd_a,
  input  dlx_pkg::fwd_sel_e fwd_b,
  input  dlx_pkg::word_t    mem_fwd,
  input  dlx_pkg::word_t    wb_fwd,
  output dlx_pkg::word_t    result,
  output dlx_pkg::word_t    store_data
);
  import dlx_pkg::*;

  word_t a_val;
  word_t b_reg;
  word_t b_val;

  // operand a source
  always_comb begin
    case (fwd_a)
      FWD_MEM: a_val = mem_fwd;
      FWD_WB:  a_val = wb_fwd;
      default: a_val = id_ex.op_a;
    endcase
  end

  // operand b source, before immediate select
  always_comb begin
    case (fwd_b)
      FWD_MEM: b_reg = mem_fwd;
      FWD_WB:  b_reg = wb_fwd;
      default: b_reg = id_ex.op_b;
    endcase
  end

  // stores write the forwarded rs2 value
  assign store_data = b_reg;
  assign b_val      = id_ex.ctrl.imm_sel ? id_ex.imm : b_reg;

  // loads and stores use add for the address
  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_ADD: result = a_val + b_val;
      ALU_SUB: result = a_val - b_val;
      ALU_AND: result = a_val & b_val;
      ALU_OR:  result = a_val | b_val;
      ALU_XOR: result = a_val ^ b_val;
      // signed compare
      ALU_SLT: result = {31'd0, $signed(a_val) < $signed(b_val)};
      default: result = '0;
    endcase
  end

endmodule

// ==== logic/hazard_forward.sv ====
`timescale 1ns/1ps

module hazard_forward (
  input  dlx_pkg::if_id_t   if_id,
  input  dlx_pkg::id_ex_t   id_ex,
  input  dlx_pkg::ex_mem_t  ex_mem,
  input  dlx_pkg::mem_wb_t  mem_wb,
  output logic              stall,
  output dlx_pkg::fwd_sel_e fwd_a,
  output dlx_pkg::fwd_sel_e fwd_b
);
  import dlx_pkg::*;

  opcode_e  dec_op;
  reg_idx_t dec_rs1;
  reg_idx_t dec_rs2;
  logic     dec_uses_rs1;
  logic     dec_uses_rs2;
  logic     dec_branch;
  logic     ex_writes;
  logic     mem_writes;
  logic     wb_writes;
  logic     load_use;
  logic     branch_wait;

  // sources of the instruction in decode
  assign dec_op       = opcode_e'(if_id.instr[OPC_LSB +: 6]);
  assign dec_rs1      = if_id.instr[RS1_LSB +: 5];
  assign dec_rs2      = if_id.instr[RS2_LSB +: 5];
  assign dec_uses_rs1 = (dec_op != J);
  assign dec_uses_rs2 = (dec_op == RTYPE) || (dec_op == SW);
  assign dec_branch   = (dec_op == BEQZ) || (dec_op == BNEZ);

  // live register writers per stage, r0 excluded
  assign ex_writes  = id_ex.valid && id_ex.ctrl.reg_wr && (id_ex.ctrl.dest != '0);
  assign mem_writes = ex_mem.valid && ex_mem.ctrl.reg_wr && (ex_mem.ctrl.dest != '0);
  assign wb_writes  = mem_wb.valid && mem_wb.ctrl.reg_wr && (mem_wb.ctrl.dest != '0);

  // load in execute feeding decode
  assign load_use = if_id.valid && ex_writes && id_ex.ctrl.mem_rd &&
                    ((dec_uses_rs1 && (id_ex.ctrl.dest == dec_rs1)) ||
                     (dec_uses_rs2 && (id_ex.ctrl.dest == dec_rs2)));

  // branch reads the register file directly
  // wait until the producer reaches writeback
  assign branch_wait = if_id.valid && dec_branch &&
                       ((ex_writes && (id_ex.ctrl.dest == dec_rs1)) ||
                        (mem_writes && (ex_mem.ctrl.dest == dec_rs1)));

  assign stall = load_use || branch_wait;

  // memory stage is younger, so it wins
  assign fwd_a = (mem_writes && (ex_mem.ctrl.dest == id_ex.rs1)) ? FWD_MEM :
                 (wb_writes && (mem_wb.ctrl.dest == id_ex.rs1))  ? FWD_WB  : FWD_REG;
  assign fwd_b = (mem_writes && (ex_mem.ctrl.dest == id_ex.rs2)) ? FWD_MEM :
                 (wb_writes && (mem_wb.ctrl.dest == id_ex.rs2))  ? FWD_WB  : FWD_REG;

endmodule

// ==== logic/decode_ctrl.sv ====
`timescale 1ns/1ps

module decode_ctrl (
  input  dlx_pkg::if_id_t if_id,
  input  dlx_pkg::word_t  rs_val,
  output dlx_pkg::ctrl_t  ctrl,
  output dlx_pkg::word_t  imm_ext,
  output logic            branch_taken,
  output logic            jump
);
  import dlx_pkg::*;

  opcode_e     opcode;
  func_e       func;
  reg_idx_t    rs2_idx;
  reg_idx_t    rd_idx;
  logic [15:0] imm16;
  logic        zero_ext;
  logic        rs_zero;
  logic        imm_alu;
  alu_op_e     imm_op;

  // field split
  assign opcode  = opcode_e'(if_id.instr[OPC_LSB +: 6]);
  assign func    = func_e'(if_id.instr[FUNC_LSB +: 6]);
  assign rs2_idx = if_id.instr[RS2_LSB +: 5];
  assign rd_idx  = if_id.instr[RD_LSB +: 5];
  assign imm16   = if_id.instr[15:0];

  // logic immediates zero extend, rest sign extend
  assign zero_ext = (opcode == ANDI) || (opcode == ORI) || (opcode == XORI);
  assign imm_ext  = zero_ext ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};

  // branch condition on the raw register value
  assign rs_zero = (rs_val == '0);

  always_comb begin
    ctrl         = '0;
    branch_taken = 1'b0;
    jump         = 1'b0;
    imm_alu      = 1'b0;
    imm_op       = ALU_ADD;
    if (if_id.valid) begin
      case (opcode)
        RTYPE: begin
          ctrl.reg_wr = 1'b1;
          ctrl.dest   = rd_idx;
          case (func)
            FUNC_ADD: ctrl.alu_op = ALU_ADD;
            FUNC_SUB: ctrl.alu_op = ALU_SUB;
            FUNC_AND: ctrl.alu_op = ALU_AND;
            FUNC_OR:  ctrl.alu_op = ALU_OR;
            FUNC_XOR: ctrl.alu_op = ALU_XOR;
            FUNC_SLT: ctrl.alu_op = ALU_SLT;
            // unknown function, no write
            default:  ctrl = '0;
          endcase
        end
        ADDI: begin
          imm_alu = 1'b1;
          imm_op  = ALU_ADD;
        end
        SUBI: begin
          imm_alu = 1'b1;
          imm_op  = ALU_SUB;
        end
        ANDI: begin
          imm_alu = 1'b1;
          imm_op  = ALU_AND;
        end
        ORI: begin
          imm_alu = 1'b1;
          imm_op  = ALU_OR;
        end
        XORI: begin
          imm_alu = 1'b1;
          imm_op  = ALU_XOR;
        end
        SLTI: begin
          imm_alu = 1'b1;
          imm_op  = ALU_SLT;
        end
        LW: begin
          // address is rs1 plus offset
          ctrl.reg_wr     = 1'b1;
          ctrl.mem_rd     = 1'b1;
          ctrl.mem_to_reg = 1'b1;
          ctrl.imm_sel    = 1'b1;
          ctrl.dest       = rs2_idx;
        end
        SW: begin
          ctrl.mem_wr  = 1'b1;
          ctrl.imm_sel = 1'b1;
        end
        BEQZ: branch_taken = rs_zero;
        BNEZ: branch_taken = !rs_zero;
        J:    jump = 1'b1;
        default: ctrl = '0;
      endcase
      // immediate alu forms write the rs2 field
      if (imm_alu) begin
        ctrl.reg_wr  = 1'b1;
        ctrl.imm_sel = 1'b1;
        ctrl.alu_op  = imm_op;
        ctrl.dest    = rs2_idx;
      end
    end
  end

endmodule

// ==== logic/inst_fetch.sv ====
`timescale 1ns/1ps

module inst_fetch (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           stall,
  input  logic           branch_taken,
  input  logic           jump,
  input  dlx_pkg::word_t if_pc,
  input  logic [15:0]    imm16,
  input  logic [25:0]    imm26,
  output dlx_pkg::word_t pc
);
  import dlx_pkg::*;

  word_t pc_seq;
  word_t slot_pc;
  word_t br_target;
  word_t jmp_target;
  word_t pc_next;

  // next sequential fetch
  assign pc_seq = pc + 32'd4;

  // decode pc plus four is the delay slot address
  assign slot_pc = if_pc + 32'd4;

  // word offset, sign extended
  assign br_target = slot_pc + {{14{imm16[15]}}, imm16, 2'b00};

  // region-absolute, top bits from the slot address
  assign jmp_target = {slot_pc[31:28], imm26, 2'b00};

  // stall beats everything, decode redirect beats sequential
  always_comb begin
    if (stall) begin
      pc_next = pc;
    end else if (jump) begin
      pc_next = jmp_target;
    end else if (branch_taken) begin
      pc_next = br_target;
    end else begin
      pc_next = pc_seq;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic              clk,
  input  logic              rst_n,
  input  dlx_pkg::reg_idx_t rd_a_idx,
  input  dlx_pkg::reg_idx_t rd_b_idx,
  output dlx_pkg::word_t    rd_a,
  output dlx_pkg::word_t    rd_b,
  input  logic              wr_en,
  input  dlx_pkg::reg_idx_t wr_idx,
  input  dlx_pkg::word_t    wr_data
);
  import dlx_pkg::*;

  // r0 has no storage
  word_t regs [1:31];

  // write port, index 0 dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_idx != '0)) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // read a, new data wins on same-cycle write
  always_comb begin
    rd_a = '0;
    if (rd_a_idx != '0) begin
      rd_a = (wr_en && (wr_idx == rd_a_idx)) ? wr_data : regs[rd_a_idx];
    end
  end

  // read b, same bypass
  always_comb begin
    rd_b = '0;
    if (rd_b_idx != '0) begin
      rd_b = (wr_en && (wr_idx == rd_b_idx)) ? wr_data : regs[rd_b_idx];
    end
  end

endmodule

// ==== logic/dlx_pkg.sv ====
package dlx_pkg;

  ////////////////////////////////////////////////////////////
  // basic types
  ////////////////////////////////////////////////////////////

  // data and address word
  typedef logic [31:0] word_t;
  // register index, r0 reads as zero
  typedef logic [4:0]  reg_idx_t;

  // fetch starts here out of reset
  localparam word_t RESET_PC = 32'h0000_0000;

  // instruction field positions
  // opcode in [31:26], rs1 in [25:21], rs2/rd(imm) in [20:16]
  // rd for r-type in [15:11], func in [5:0]
  localparam int unsigned OPC_LSB  = 26;
  localparam int unsigned RS1_LSB  = 21;
  localparam int unsigned RS2_LSB  = 16;
  localparam int unsigned RD_LSB   = 11;
  localparam int unsigned FUNC_LSB = 0;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  // primary opcodes, dlx numbering
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQZ  = 6'h04,
    BNEZ  = 6'h05,
    ADDI  = 6'h08,
    SUBI  = 6'h0a,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    XORI  = 6'h0e,
    SLTI  = 6'h1a,
    LW    = 6'h23,
    SW    = 6'h2b
  } opcode_e;

  // r-type function field
  typedef enum logic [5:0] {
    FUNC_ADD = 6'h20,
    FUNC_SUB = 6'h22,
    FUNC_AND = 6'h24,
    FUNC_OR  = 6'h25,
    FUNC_XOR = 6'h26,
    FUNC_SLT = 6'h2a
  } func_e;

  // alu operation select
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5
  } alu_op_e;

  // operand source for execute
  typedef enum logic [1:0] {
    FWD_REG = 2'd0,
    FWD_MEM = 2'd1,
    FWD_WB  = 2'd2
  } fwd_sel_e;

  ////////////////////////////////////////////////////////////
  // control and stage payloads
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic     reg_wr;
    logic     mem_rd;
    logic     mem_wr;
    logic     mem_to_reg;
    // operand b from the extended immediate
    logic     imm_sel;
    alu_op_e  alu_op;
    reg_idx_t dest;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc;
  } if_id_t;

  typedef struct packed {
    logic     valid;
    ctrl_t    ctrl;
    word_t    op_a;
    word_t    op_b;
    word_t    imm;
    reg_idx_t rs1;
    reg_idx_t rs2;
  } id_ex_t;

  typedef struct packed {
    logic  valid;
    ctrl_t ctrl;
    word_t alu_result;
    word_t store_data;
  } ex_mem_t;

  typedef struct packed {
    logic  valid;
    ctrl_t ctrl;
    word_t alu_result;
    word_t load_data;
  } mem_wb_t;

endpackage
